// File: Makefile
VERILATOR ?= verilator
TOP       := slice_tb
FILELIST  := simd_fp_slice.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --Mdir $(OBJ_DIR)
LINTFLAGS := --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)

run: build
	@out="$$(./$(OBJ_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: logic/lane_op.sv
// Single lane min/max and sign injection for FP32 or FP16 values
`timescale 1ns/1ns
`default_nettype none

module lane_op (
  input  logic [simd_fp_pkg::WORD_WIDTH-1:0] a_i,
  input  logic [simd_fp_pkg::WORD_WIDTH-1:0] b_i,
  input  simd_fp_pkg::operation_e            op_i,
  input  simd_fp_pkg::fp_format_e            fmt_i,
  output logic [simd_fp_pkg::WORD_WIDTH-1:0] result_o,
  output simd_fp_pkg::status_t               status_o
);

  localparam int unsigned W = simd_fp_pkg::WORD_WIDTH;

  logic [W-1:0] a_val, b_val, canon_nan, sgnj_res;
  logic [W-2:0] a_mag, b_mag;
  logic         a_sign, b_sign, a_nan, b_nan, a_snan, b_snan;
  logic         a_lt_b, res_sign, is_minmax;

  // ------------------------------------------------------------------------
  // Operand classification
  // ------------------------------------------------------------------------
  always_comb begin : classify
    if (fmt_i == simd_fp_pkg::FP32) begin
      a_val     = a_i;
      b_val     = b_i;
      a_mag     = a_i[30:0];
      b_mag     = b_i[30:0];
      a_sign    = a_i[31];
      b_sign    = b_i[31];
      a_nan     = (&a_i[30:23]) & (|a_i[22:0]);
      b_nan     = (&b_i[30:23]) & (|b_i[22:0]);
      a_snan    = a_nan & ~a_i[22]; // Quiet bit clear
      b_snan    = b_nan & ~b_i[22];
      canon_nan = 32'h7fc0_0000;
    end else begin
      a_val     = {16'b0, a_i[15:0]}; // Upper half of the lane is ignored
      b_val     = {16'b0, b_i[15:0]};
      a_mag     = {16'b0, a_i[14:0]};
      b_mag     = {16'b0, b_i[14:0]};
      a_sign    = a_i[15];
      b_sign    = b_i[15];
      a_nan     = (&a_i[14:10]) & (|a_i[9:0]);
      b_nan     = (&b_i[14:10]) & (|b_i[9:0]);
      a_snan    = a_nan & ~a_i[9];
      b_snan    = b_nan & ~b_i[9];
      canon_nan = 32'h0000_7e00;
    end
  end

  // Ordering where -0 sits below +0
  assign a_lt_b = (a_sign != b_sign) ? a_sign :
                  a_sign             ? (a_mag > b_mag) : (a_mag < b_mag);

  assign is_minmax = (op_i == simd_fp_pkg::MIN) | (op_i == simd_fp_pkg::MAX);

  always_comb begin : sign_inject
    case (op_i)
      simd_fp_pkg::SGNJ:  res_sign = b_sign;
      simd_fp_pkg::SGNJN: res_sign = ~b_sign;
      simd_fp_pkg::SGNJX: res_sign = a_sign ^ b_sign;
      default:            res_sign = a_sign;
    endcase
    sgnj_res = (fmt_i == simd_fp_pkg::FP32) ? {res_sign, a_i[30:0]}
                                            : {16'b0, res_sign, a_i[14:0]};
  end

  always_comb begin : select_result
    result_o = sgnj_res;
    status_o = '0; // Sign injection is always quiet
    if (is_minmax) begin
      status_o.nv = a_snan | b_snan;
      if (a_nan && b_nan)                           result_o = canon_nan;
      else if (a_nan)                               result_o = b_val;
      else if (b_nan)                               result_o = a_val;
      else if ((op_i == simd_fp_pkg::MIN) == a_lt_b) result_o = a_val;
      else                                          result_o = b_val;
    end
  end

endmodule

`default_nettype wire

// File: logic/lane_stage.sv
// Lane stage that runs min/max and sign injection on every lane and registers the results
`timescale 1ns/1ns
`default_nettype none

module lane_stage #(
  parameter int unsigned TagWidth = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  simd_fp_pkg::decode_out_t   in_i,
  input  logic [TagWidth-1:0]        tag_i,
  input  logic                       in_valid_i,
  output logic                       in_ready_o,
  input  logic                       flush_i,
  output simd_fp_pkg::lane_out_t     out_o,
  output logic [TagWidth-1:0]        tag_o,
  output logic                       out_valid_o,
  input  logic                       out_ready_i
);

  localparam int unsigned W    = simd_fp_pkg::WORD_WIDTH;
  localparam int unsigned NL   = simd_fp_pkg::NUM_LANES;
  localparam int unsigned HALF = W / NL;

  logic [NL-1:0][W-1:0]           lane_a, lane_b, lane_res;
  simd_fp_pkg::status_t [NL-1:0]  lane_status;
  simd_fp_pkg::lane_out_t         out_d, out_q;
  logic                           valid_q;
  logic [TagWidth-1:0]            tag_q;

  // ------------------------------------------------------------------------
  // Lanes
  // ------------------------------------------------------------------------
  for (genvar l = 0; l < NL; l++) begin : gen_lanes
    // FP16 lanes see their own half, FP32 uses the whole word
    assign lane_a[l] = (in_i.ctrl.fmt == simd_fp_pkg::FP32) ? in_i.a.fp32
                                                            : {{(W-HALF){1'b0}}, in_i.a.fp16[l]};
    assign lane_b[l] = (in_i.ctrl.fmt == simd_fp_pkg::FP32) ? in_i.b.fp32
                                                            : {{(W-HALF){1'b0}}, in_i.b.fp16[l]};

    lane_op i_lane_op (
      .a_i      ( lane_a[l]      ),
      .b_i      ( lane_b[l]      ),
      .op_i     ( in_i.ctrl.op   ),
      .fmt_i    ( in_i.ctrl.fmt  ),
      .result_o ( lane_res[l]    ),
      .status_o ( lane_status[l] )
    );
  end

  always_comb begin : gather
    out_d.ctrl        = in_i.ctrl;
    out_d.lane_en     = in_i.lane_en;
    out_d.result.fp32 = lane_res[0]; // FP32 result lives in lane 0
    if (in_i.ctrl.fmt == simd_fp_pkg::FP16) begin
      for (int l = 0; l < NL; l++) begin
        out_d.result.fp16[l] = lane_res[l][HALF-1:0];
      end
    end
    for (int l = 0; l < NL; l++) begin
      out_d.status[l] = in_i.lane_en[l] ? lane_status[l] : '0;
    end
  end

  // ------------------------------------------------------------------------
  // Stage register
  // ------------------------------------------------------------------------
  assign in_ready_o = out_ready_i | ~valid_q; // Holds data under back-pressure

  always_ff @(posedge clk_i or negedge rst_n_i) begin : valid_reg
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin : data_reg
    if (in_ready_o && in_valid_i) begin
      out_q <= out_d;
      tag_q <= tag_i;
    end
  end

  assign out_o       = out_q;
  assign tag_o       = tag_q;
  assign out_valid_o = valid_q;

endmodule

`default_nettype wire

// File: logic/result_pack.sv
// Output packer that NaN-boxes unused FP16 lanes and collapses lane status
`timescale 1ns/1ns
`default_nettype none

module result_pack (
  input  simd_fp_pkg::lane_out_t in_i,
  output simd_fp_pkg::operand_u  result_o,
  output simd_fp_pkg::status_t   status_o
);

  localparam int unsigned NL = simd_fp_pkg::NUM_LANES;

  simd_fp_pkg::status_t status_acc;

  // ------------------------------------------------------------------------
  // Result word
  // ------------------------------------------------------------------------
  // FP32 and vector FP16 words already sit in place after the lane stage.
  // A scalar FP16 result only fills lane 0, so the idle upper lane is
  // filled with ones to keep the value NaN-boxed for wider consumers.
  always_comb begin : pack_result
    result_o = in_i.result;
    if (in_i.ctrl.fmt == simd_fp_pkg::FP16) begin
      for (int l = 0; l < NL; l++) begin
        if (!in_i.lane_en[l]) begin
          result_o.fp16[l] = '1; // NaN box
        end
      end
    end
  end

  // ------------------------------------------------------------------------
  // Status
  // ------------------------------------------------------------------------
  always_comb begin : collapse_status
    status_acc = '0;
    for (int l = 0; l < NL; l++) begin
      if (in_i.lane_en[l]) begin
        status_acc = simd_fp_pkg::status_t'(status_acc | in_i.status[l]);
      end
    end
    status_o = status_acc;
  end

endmodule

`default_nettype wire

// File: logic/simd_fp_pkg.sv
// SIMD FP slice package with formats, operations, status flags and stage payloads
`default_nettype none

package simd_fp_pkg;

  // ------------------------------------------------------------------------
  // Slice geometry
  // ------------------------------------------------------------------------
  localparam int unsigned WORD_WIDTH = 32; // One slice word
  localparam int unsigned NUM_LANES  = 2;  // FP16 vectors use two lanes

  // ------------------------------------------------------------------------
  // Formats and operations
  // ------------------------------------------------------------------------
  typedef enum logic {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_format_e;

  typedef enum logic [2:0] {
    MIN   = 3'd0,
    MAX   = 3'd1,
    SGNJ  = 3'd2, // Take sign of b
    SGNJN = 3'd3, // Take inverted sign of b
    SGNJX = 3'd4  // XOR of both signs
  } operation_e;

  // IEEE exception flags of which only nv can be raised by this group
  typedef struct packed {
    logic nv; // Invalid
    logic dz; // Divide by zero
    logic of; // Overflow
    logic uf; // Underflow
    logic nx; // Inexact
  } status_t;

  // One word seen as a single FP32 value or as two FP16 lanes (lane 0 low)
  typedef union packed {
    logic [WORD_WIDTH-1:0]                          fp32;
    logic [NUM_LANES-1:0][WORD_WIDTH/NUM_LANES-1:0] fp16;
  } operand_u;

  // Control that travels with the data
  typedef struct packed {
    operation_e op;
    fp_format_e fmt;
    logic       vectorial;
  } lane_ctrl_t;

  // ------------------------------------------------------------------------
  // Stage payloads
  // ------------------------------------------------------------------------
  typedef struct packed {
    operand_u             a;
    operand_u             b;
    lane_ctrl_t           ctrl;
    logic [NUM_LANES-1:0] lane_en;
  } decode_out_t;

  typedef struct packed {
    operand_u                  result;
    status_t [NUM_LANES-1:0]   status; // Per-lane flags with disabled lanes cleared
    lane_ctrl_t                ctrl;
    logic    [NUM_LANES-1:0]   lane_en;
  } lane_out_t;

endpackage

`default_nettype wire

// File: logic/simd_fp_slice.sv
// SIMD floating-point slice top for min/max and sign injection on FP32 and FP16 lanes
`timescale 1ns/1ns
`default_nettype none

module simd_fp_slice #(
  parameter int unsigned TagWidth = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // Input side
  input  simd_fp_pkg::operand_u    a_i,
  input  simd_fp_pkg::operand_u    b_i,
  input  simd_fp_pkg::operation_e  op_i,
  input  simd_fp_pkg::fp_format_e  fmt_i,
  input  logic                     vectorial_i,
  input  logic [TagWidth-1:0]      tag_i,
  input  logic                     in_valid_i,
  output logic                     in_ready_o,
  input  logic                     flush_i,
  // Output side
  output simd_fp_pkg::operand_u    result_o,
  output simd_fp_pkg::status_t     status_o,
  output logic [TagWidth-1:0]      tag_o,
  output logic                     out_valid_o,
  input  logic                     out_ready_i,
  output logic                     busy_o
);

  simd_fp_pkg::decode_out_t dec_out;
  simd_fp_pkg::lane_out_t   lane_out;
  logic [TagWidth-1:0]      dec_tag;
  logic                     dec_valid, lane_ready, lane_valid;

  slice_decode #(
    .TagWidth ( TagWidth )
  ) i_slice_decode (
    .clk_i,
    .rst_n_i,
    .a_i,
    .b_i,
    .op_i,
    .fmt_i,
    .vectorial_i,
    .tag_i,
    .in_valid_i,
    .in_ready_o,
    .flush_i,
    .out_o       ( dec_out    ),
    .tag_o       ( dec_tag    ),
    .out_valid_o ( dec_valid  ),
    .out_ready_i ( lane_ready )
  );

  lane_stage #(
    .TagWidth ( TagWidth )
  ) i_lane_stage (
    .clk_i,
    .rst_n_i,
    .in_i        ( dec_out    ),
    .tag_i       ( dec_tag    ),
    .in_valid_i  ( dec_valid  ),
    .in_ready_o  ( lane_ready ),
    .flush_i,
    .out_o       ( lane_out   ),
    .tag_o,
    .out_valid_o ( lane_valid ),
    .out_ready_i
  );

  result_pack i_result_pack (
    .in_i     ( lane_out ),
    .result_o,
    .status_o
  );

  assign out_valid_o = lane_valid;
  assign busy_o      = dec_valid | lane_valid; // Anything in flight

endmodule

`default_nettype wire

// File: logic/slice_decode.sv
// Decode stage that checks FP16 NaN boxing, splits operands into lanes and registers them
`timescale 1ns/1ns
`default_nettype none

module slice_decode #(
  parameter int unsigned TagWidth = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  simd_fp_pkg::operand_u      a_i,
  input  simd_fp_pkg::operand_u      b_i,
  input  simd_fp_pkg::operation_e    op_i,
  input  simd_fp_pkg::fp_format_e    fmt_i,
  input  logic                       vectorial_i,
  input  logic [TagWidth-1:0]        tag_i,
  input  logic                       in_valid_i,
  output logic                       in_ready_o,
  input  logic                       flush_i,
  output simd_fp_pkg::decode_out_t   out_o,
  output logic [TagWidth-1:0]        tag_o,
  output logic                       out_valid_o,
  input  logic                       out_ready_i
);

  // Scalar FP16 operand must have an all-ones upper half, otherwise it reads as qNaN
  function automatic simd_fp_pkg::operand_u nan_box_check(simd_fp_pkg::operand_u op,
                                                          logic scalar_h);
    simd_fp_pkg::operand_u res;
    res = op;
    if (scalar_h && (op.fp16[1] != '1)) begin
      res.fp16[0] = 16'h7e00;
    end
    return res;
  endfunction

  simd_fp_pkg::decode_out_t out_d, out_q;
  logic                     scalar_h;
  logic                     valid_q;
  logic [TagWidth-1:0]      tag_q;

  assign scalar_h = (fmt_i == simd_fp_pkg::FP16) & ~vectorial_i;

  always_comb begin : decode
    out_d.a              = nan_box_check(a_i, scalar_h);
    out_d.b              = nan_box_check(b_i, scalar_h);
    out_d.ctrl.op        = op_i;
    out_d.ctrl.fmt       = fmt_i;
    out_d.ctrl.vectorial = vectorial_i;
    out_d.lane_en[0]     = 1'b1; // Lane 0 always runs
    out_d.lane_en[1]     = (fmt_i == simd_fp_pkg::FP16) & vectorial_i;
  end

  // ------------------------------------------------------------------------
  // Stage register
  // ------------------------------------------------------------------------
  assign in_ready_o = out_ready_i | ~valid_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin : valid_reg
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin : data_reg
    if (in_ready_o && in_valid_i) begin
      out_q <= out_d;
      tag_q <= tag_i; // Tag follows its item
    end
  end

  assign out_o       = out_q;
  assign tag_o       = tag_q;
  assign out_valid_o = valid_q;

endmodule

`default_nettype wire

// File: simd_fp_slice.f
logic/simd_fp_pkg.sv
logic/lane_op.sv
logic/slice_decode.sv
logic/lane_stage.sv
logic/result_pack.sv
logic/simd_fp_slice.sv
verif/slice_tb_clock.sv
verif/slice_tb.sv

// File: verif/slice_tb.sv
// Directed testbench for the SIMD FP slice with a reference model and typed compare tasks
`timescale 1ns/1ns
`default_nettype none

module slice_tb;

  localparam int unsigned TAG_W    = 4;
  localparam int unsigned TIMEOUT  = 200;
  localparam int unsigned BP_ITEMS = 12;
  localparam int unsigned NUM_SP   = 6;

  localparam logic [31:0] SP32 [NUM_SP] = '{32'h0000_0000, 32'h8000_0000, 32'h7fc0_0001,
                                            32'h7f80_0001, 32'h3f80_0000, 32'hc000_0000};
  localparam logic [15:0] SP16 [NUM_SP] = '{16'h0000, 16'h8000, 16'h7e00,
                                            16'h7c01, 16'h3c00, 16'hc000};

  typedef struct packed {
    simd_fp_pkg::operand_u   a;
    simd_fp_pkg::operand_u   b;
    simd_fp_pkg::operation_e op;
    simd_fp_pkg::fp_format_e fmt;
    logic                    vec;
    logic [TAG_W-1:0]        tag;
  } item_t;

  logic                    clk_i, rst_n_i;
  simd_fp_pkg::operand_u   a_i, b_i, result_o;
  simd_fp_pkg::operation_e op_i;
  simd_fp_pkg::fp_format_e fmt_i;
  simd_fp_pkg::status_t    status_o;
  logic                    vectorial_i, in_valid_i, in_ready_o, flush_i;
  logic                    out_valid_o, out_ready_i, busy_o;
  logic [TAG_W-1:0]        tag_i, tag_o, tag_cnt;
  integer                  seed;
  item_t                   bp_items[$];

  slice_tb_clock i_clock (
    .clk_o   ( clk_i   ),
    .rst_n_o ( rst_n_i )
  );

  simd_fp_slice #(
    .TagWidth ( TAG_W )
  ) dut_i (
    .clk_i, .rst_n_i, .a_i, .b_i, .op_i, .fmt_i, .vectorial_i, .tag_i, .in_valid_i,
    .in_ready_o, .flush_i, .result_o, .status_o, .tag_o, .out_valid_o, .out_ready_i, .busy_o
  );

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------
  // One lane with right-aligned values where half selects FP16
  function automatic logic [31:0] model_lane(input logic [31:0] a, input logic [31:0] b,
                                             input simd_fp_pkg::operation_e op,
                                             input logic half, output logic nv);
    logic [31:0] x, y, sbit, inf, qbit, qnan, ka, kb, res;
    logic        a_nan, b_nan, a_sig, b_sig, new_sign;
    x     = half ? {16'h0, a[15:0]} : a;
    y     = half ? {16'h0, b[15:0]} : b;
    sbit  = half ? 32'h0000_8000 : 32'h8000_0000;
    inf   = half ? 32'h0000_7c00 : 32'h7f80_0000;
    qbit  = half ? 32'h0000_0200 : 32'h0040_0000;
    qnan  = half ? 32'h0000_7e00 : 32'h7fc0_0000;
    a_nan = (x & ~sbit) > inf;
    b_nan = (y & ~sbit) > inf;
    a_sig = a_nan && ((x & qbit) == 32'h0);
    b_sig = b_nan && ((y & qbit) == 32'h0);
    // Map to an unsigned total order with -0 below +0
    ka    = half ? (x << 16) : x;
    kb    = half ? (y << 16) : y;
    ka    = ka[31] ? ~ka : (ka | 32'h8000_0000);
    kb    = kb[31] ? ~kb : (kb | 32'h8000_0000);
    nv    = 1'b0;
    case (op)
      simd_fp_pkg::MIN, simd_fp_pkg::MAX: begin
        nv = a_sig | b_sig;
        if (a_nan && b_nan)            res = qnan;
        else if (a_nan)                res = y;
        else if (b_nan)                res = x;
        else if (op == simd_fp_pkg::MIN) res = (ka < kb) ? x : y;
        else                           res = (ka > kb) ? x : y;
      end
      default: begin
        case (op)
          simd_fp_pkg::SGNJ:  new_sign = (y & sbit) != 32'h0;
          simd_fp_pkg::SGNJN: new_sign = (y & sbit) == 32'h0;
          simd_fp_pkg::SGNJX: new_sign = ((x ^ y) & sbit) != 32'h0;
          default:            new_sign = (x & sbit) != 32'h0;
        endcase
        res = (x & ~sbit) | (new_sign ? sbit : 32'h0);
      end
    endcase
    return res;
  endfunction

  function automatic simd_fp_pkg::operand_u expect_word(input item_t it,
                                                        output simd_fp_pkg::status_t st);
    simd_fp_pkg::operand_u a, b, r;
    logic [31:0]           r0, r1;
    logic                  nv0, nv1;
    a   = it.a;
    b   = it.b;
    nv1 = 1'b0;
    st  = '0;
    if (it.fmt == simd_fp_pkg::FP32) begin
      r.fp32 = model_lane(a.fp32, b.fp32, it.op, 1'b0, nv0);
    end else begin
      if (!it.vec) begin // Badly boxed scalar reads as canonical NaN
        if (a.fp16[1] != 16'hffff) a.fp16[0] = 16'h7e00;
        if (b.fp16[1] != 16'hffff) b.fp16[0] = 16'h7e00;
      end
      r0        = model_lane({16'h0, a.fp16[0]}, {16'h0, b.fp16[0]}, it.op, 1'b1, nv0);
      r.fp16[0] = r0[15:0];
      if (it.vec) begin
        r1        = model_lane({16'h0, a.fp16[1]}, {16'h0, b.fp16[1]}, it.op, 1'b1, nv1);
        r.fp16[1] = r1[15:0];
      end else begin
        r.fp16[1] = 16'hffff;
      end
    end
    st.nv = nv0 | nv1;
    return r;
  endfunction

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------
  task automatic fail_now(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    fail_now($sformatf("Mismatch at %0t ns: %s = %h, expected %h", $time, name, got, exp));
  endtask

  task automatic compare_result(input string name, input simd_fp_pkg::operand_u got,
                                input simd_fp_pkg::operand_u exp);
    if (got !== exp) report_mismatch(name, got.fp32, exp.fp32);
  endtask

  task automatic compare_status(input string name, input simd_fp_pkg::status_t got,
                                input simd_fp_pkg::status_t exp);
    if (got !== exp) report_mismatch(name, {27'h0, got}, {27'h0, exp});
  endtask

  task automatic compare_tag(input string name, input logic [TAG_W-1:0] got,
                             input logic [TAG_W-1:0] exp);
    if (got !== exp) report_mismatch(name, {{(32-TAG_W){1'b0}}, got}, {{(32-TAG_W){1'b0}}, exp});
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    if (got !== exp) report_mismatch(name, {31'h0, got}, {31'h0, exp});
  endtask

  task automatic compare_count(input string name, input int unsigned got, input int unsigned exp);
    if (got != exp) report_mismatch(name, got, exp);
  endtask

  task automatic check_item(input item_t it);
    simd_fp_pkg::operand_u exp_res;
    simd_fp_pkg::status_t  exp_st;
    exp_res = expect_word(it, exp_st);
    compare_result("result_o", result_o, exp_res);
    compare_status("status_o", status_o, exp_st);
    compare_tag("tag_o", tag_o, it.tag);
  endtask

  // --------------------------------------------------------------------------
  // Stimulus helpers entered and left 1 ns after a rising edge
  // --------------------------------------------------------------------------
  function automatic logic [31:0] rnd_word();
    return $random(seed);
  endfunction

  function automatic item_t make_item(input simd_fp_pkg::fp_format_e fmt, input logic vec,
                                      input simd_fp_pkg::operation_e op,
                                      input logic [31:0] a, input logic [31:0] b);
    item_t it;
    it.a.fp32 = a;
    it.b.fp32 = b;
    it.op     = op;
    it.fmt    = fmt;
    it.vec    = vec;
    it.tag    = tag_cnt;
    tag_cnt   = tag_cnt + TAG_W'(1);
    return it;
  endfunction

  task automatic send_item(input item_t it);
    int unsigned waited;
    waited      = 0;
    a_i         = it.a;
    b_i         = it.b;
    op_i        = it.op;
    fmt_i       = it.fmt;
    vectorial_i = it.vec;
    tag_i       = it.tag;
    in_valid_i  = 1'b1;
    #1;
    while (!in_ready_o) begin
      @(posedge clk_i);
      #2;
      waited++;
      if (waited > TIMEOUT) fail_now("Input handshake timed out, in_ready_o stayed low");
    end
    @(posedge clk_i); // Accepted here
    #1;
    in_valid_i = 1'b0;
  endtask

  task automatic get_result(input item_t it);
    int unsigned waited;
    waited      = 0;
    out_ready_i = 1'b1;
    #1;
    while (!out_valid_o) begin
      @(posedge clk_i);
      #2;
      waited++;
      if (waited > TIMEOUT) fail_now("No result arrived, out_valid_o stayed low");
    end
    check_item(it);
    @(posedge clk_i);
    #1;
  endtask

  task automatic run_item(input item_t it);
    send_item(it);
    get_result(it);
  endtask

  // --------------------------------------------------------------------------
  // Directed tests
  // --------------------------------------------------------------------------
  task automatic test_fp32_minmax();
    for (int i = 0; i < 12; i++) begin
      run_item(make_item(simd_fp_pkg::FP32, 1'b0, (i % 2 == 1) ? simd_fp_pkg::MAX
                         : simd_fp_pkg::MIN, rnd_word(), rnd_word()));
    end
    for (int i = 0; i < NUM_SP; i++) begin
      for (int j = 0; j < NUM_SP; j++) begin
        run_item(make_item(simd_fp_pkg::FP32, 1'b0, simd_fp_pkg::MIN, SP32[i], SP32[j]));
        run_item(make_item(simd_fp_pkg::FP32, 1'b0, simd_fp_pkg::MAX, SP32[i], SP32[j]));
      end
    end
  endtask

  task automatic test_fp16_vector();
    simd_fp_pkg::operation_e op;
    logic [31:0]             r;
    for (int k = 0; k < 5; k++) begin
      op = simd_fp_pkg::operation_e'(3'(k));
      for (int i = 0; i < 6; i++) begin
        run_item(make_item(simd_fp_pkg::FP16, 1'b1, op, rnd_word(), rnd_word()));
      end
      for (int i = 0; i < NUM_SP; i++) begin
        for (int j = 0; j < NUM_SP; j++) begin
          r = rnd_word();
          run_item(make_item(simd_fp_pkg::FP16, 1'b1, op, {SP16[j], SP16[i]},
                             {SP16[i], r[15:0]}));
        end
      end
    end
  endtask

  task automatic test_fp16_scalar();
    logic [31:0] ra, rb;
    for (int i = 0; i < 15; i++) begin
      ra = rnd_word();
      rb = rnd_word();
      run_item(make_item(simd_fp_pkg::FP16, 1'b0, simd_fp_pkg::operation_e'(3'(i % 5)),
                         {16'hffff, ra[15:0]}, {16'hffff, rb[15:0]}));
      // Unboxed b turns into NaN, MAX then returns a
      run_item(make_item(simd_fp_pkg::FP16, 1'b0, simd_fp_pkg::MAX,
                         {16'hffff, ra[15:0]}, {rb[31:16] & 16'h7fff, rb[15:0]}));
      run_item(make_item(simd_fp_pkg::FP16, 1'b0, simd_fp_pkg::MIN,
                         {ra[31:16] & 16'h7fff, ra[15:0]}, {rb[31:16] & 16'h7fff, rb[15:0]}));
    end
  endtask

  task automatic test_sign_inject();
    simd_fp_pkg::operation_e op;
    for (int k = 2; k < 5; k++) begin
      op = simd_fp_pkg::operation_e'(3'(k));
      for (int i = 0; i < 8; i++) begin
        run_item(make_item(simd_fp_pkg::FP32, 1'b0, op, rnd_word(), rnd_word()));
      end
      for (int i = 0; i < NUM_SP; i++) begin
        for (int j = 0; j < NUM_SP; j++) begin
          run_item(make_item(simd_fp_pkg::FP32, 1'b0, op, SP32[i], SP32[j]));
        end
      end
    end
  endtask

  task automatic test_latency();
    item_t       it;
    int unsigned cycles;
    it          = make_item(simd_fp_pkg::FP32, 1'b0, simd_fp_pkg::MAX, rnd_word(), rnd_word());
    out_ready_i = 1'b1;
    send_item(it);
    cycles = 1;
    #1;
    while (!out_valid_o) begin
      @(posedge clk_i);
      #2;
      cycles++;
      if (cycles > TIMEOUT) fail_now("Latency test timed out, out_valid_o stayed low");
    end
    compare_count("latency", cycles, 2);
    check_item(it);
    @(posedge clk_i);
    #1;
  endtask

  task automatic test_backpressure();
    logic [31:0] r;
    int unsigned got, waited;
    got    = 0;
    waited = 0;
    for (int unsigned i = 0; i < BP_ITEMS; i++) begin
      r = rnd_word();
      bp_items.push_back(make_item(simd_fp_pkg::fp_format_e'(r[0]), r[1],
                                   simd_fp_pkg::operation_e'(3'(r[31:8] % 24'd5)),
                                   rnd_word(), rnd_word()));
    end
    fork
      begin : sender
        for (int unsigned i = 0; i < BP_ITEMS; i++) send_item(bp_items[i]);
      end
      begin : receiver
        while (got < BP_ITEMS) begin
          r           = rnd_word();
          out_ready_i = r[0];
          #1;
          if (out_valid_o && out_ready_i) begin
            check_item(bp_items[got]);
            got++;
          end
          @(posedge clk_i);
          #1;
          waited++;
          if (waited > TIMEOUT) fail_now("Back-pressure test timed out before all results");
        end
        out_ready_i = 1'b1;
      end
    join
    // Nothing left over or duplicated
    for (int i = 0; i < 4; i++) begin
      #1;
      compare_flag("out_valid_o", out_valid_o, 1'b0);
      compare_flag("busy_o", busy_o, 1'b0);
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic test_flush();
    out_ready_i = 1'b0; // Keep both stages full
    send_item(make_item(simd_fp_pkg::FP32, 1'b0, simd_fp_pkg::MIN, rnd_word(), rnd_word()));
    send_item(make_item(simd_fp_pkg::FP32, 1'b0, simd_fp_pkg::MAX, rnd_word(), rnd_word()));
    flush_i = 1'b1;
    #1;
    compare_flag("busy_o", busy_o, 1'b1);
    compare_flag("out_valid_o", out_valid_o, 1'b1);
    compare_flag("in_ready_o", in_ready_o, 1'b0); // Both stages hold an item
    @(posedge clk_i);
    #1;
    flush_i     = 1'b0;
    out_ready_i = 1'b1;
    for (int i = 0; i < 5; i++) begin
      #1;
      compare_flag("out_valid_o", out_valid_o, 1'b0);
      compare_flag("busy_o", busy_o, 1'b0);
      @(posedge clk_i);
      #1;
    end
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin : main
    int unsigned waited;
    seed        = 32'h77f2_960f;
    tag_cnt     = '0;
    a_i         = '0;
    b_i         = '0;
    op_i        = simd_fp_pkg::MIN;
    fmt_i       = simd_fp_pkg::FP32;
    vectorial_i = 1'b0;
    tag_i       = '0;
    in_valid_i  = 1'b0;
    flush_i     = 1'b0;
    out_ready_i = 1'b1;
    waited      = 0;
    while (rst_n_i !== 1'b1) begin
      @(posedge clk_i);
      waited++;
      if (waited > TIMEOUT) fail_now("Reset was never released");
    end
    @(posedge clk_i);
    #2;
    compare_flag("in_ready_o", in_ready_o, 1'b1);
    compare_flag("out_valid_o", out_valid_o, 1'b0);
    compare_flag("busy_o", busy_o, 1'b0);
    @(posedge clk_i);
    #1;
    test_fp32_minmax();
    test_fp16_vector();
    test_fp16_scalar();
    test_sign_inject();
    test_latency();
    test_backpressure();
    test_flush();
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/slice_tb_clock.sv
// Testbench clock and reset generator for the SIMD FP slice
`timescale 1ns/1ns
`default_nettype none

module slice_tb_clock (
  output logic clk_o,
  output logic rst_n_o
);

  localparam int unsigned HalfPeriod  = 4; // 8 ns clock
  localparam int unsigned ResetCycles = 8;

  initial begin
    clk_o = 1'b0;
    forever #HalfPeriod clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1 rst_n_o = 1'b1; // Release just after an edge
  end

endmodule

`default_nettype wire
